/* char_fetch.sv */
`include "vid_config.svh"

module char_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [8:0]              h,
    input  logic [8:0]              v,
    output logic                    rom_req,
    output logic [`VID_ROM_AW-1:0]  rom_addr,
    input  logic                    rom_ack,
    input  vid_pkg::row_t           rom_data,
    output vid_pkg::row_t           row,
    output logic                    row_ok,
    input  logic                    load
);

    localparam logic [8:0] h_start = 9'(`VID_H_START);
    localparam logic [8:0] h_end   = 9'(`VID_H_END);
    localparam logic [8:0] v_start = 9'(`VID_V_START);
    localparam logic [8:0] v_end   = 9'(`VID_V_END);

    vid_pkg::fetch_state_t state;

    logic                   tile_start;
    logic                   stale;
    logic                   row_take;
    logic [8:0]             v_next;
    logic [`VID_ROM_AW-1:0] next_addr;

    // first pixel of a tile, fetch for the following tile begins here
    assign tile_start = cen && (h[2:0] == 3'd0);

    // next tile address, column 63 rolls over to column 16 of the next line
    always_comb begin
        v_next = (v == v_end) ? v_start : v + 9'd1;
        if (h[8:3] == h_end[8:3]) begin
            next_addr = {v_next[7:0], h_start[8:3]};
        end else begin
            next_addr = {v[7:0], h[8:3] + 6'd1};
        end
    end

    // data is kept only if its tile has not been loaded yet
    assign row_take = (state == vid_pkg::fetch_req) && rom_ack && !stale && !load;

    // four-phase master
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= vid_pkg::fetch_idle;
            rom_req <= 1'b0;
            row_ok  <= 1'b0;
            stale   <= 1'b0;
        end else begin
            // shifter took the row, wait for a fresh one
            if (load) row_ok <= 1'b0;
            case (state)
                vid_pkg::fetch_idle: begin
                    // a tile start missed while busy is simply skipped
                    if (tile_start && !rom_ack) begin
                        rom_req <= 1'b1;
                        stale   <= 1'b0;
                        state   <= vid_pkg::fetch_req;
                    end
                end
                vid_pkg::fetch_req: begin
                    if (rom_ack) begin
                        rom_req <= 1'b0;
                        state   <= vid_pkg::fetch_release;
                        if (row_take) row_ok <= 1'b1;
                    end else if (load) begin
                        // too late for its tile, throw the data away
                        stale <= 1'b1;
                    end
                end
                vid_pkg::fetch_release: begin
                    if (!rom_ack) state <= vid_pkg::fetch_idle;
                end
                default: begin
                    rom_req <= 1'b0;
                    state   <= vid_pkg::fetch_idle;
                end
            endcase
        end
    end

    // address is set with req and then held through the handshake
    always_ff @(posedge clk) begin
        if (state == vid_pkg::fetch_idle && tile_start && !rom_ack) begin
            rom_addr <= next_addr;
        end
    end

    // row register, written on the edge that sees ack
    always_ff @(posedge clk) begin
        if (row_take) row <= rom_data;
    end

    // req is only withdrawn after the ROM has answered
    assert property (@(posedge clk) disable iff (rst)
        $past(rom_req) && !$past(rom_ack) && !$past(rst) |-> rom_req);

    // ROM sees a steady address while req or ack is up
    assert property (@(posedge clk) disable iff (rst)
        ($past(rom_req) || $past(rom_ack)) && !$past(rst) |-> $stable(rom_addr));

endmodule

/* char_shifter.sv */
`include "vid_config.svh"

module char_shifter (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic [8:0]     h,
    input  logic [8:0]     v,
    input  logic           lhbl,
    input  logic           lvbl,
    input  logic           lhbl_obj,
    input  logic           lvbl_obj,
    input  logic           hs,
    input  logic           vs,
    input  vid_pkg::row_t  row,
    input  logic           row_ok,
    output logic           load,
    output vid_pkg::pixel_t pix,
    output logic [8:0]     h_out,
    output logic [8:0]     v_out,
    output logic           lhbl_out,
    output logic           lvbl_out,
    output logic           lhbl_obj_out,
    output logic           lvbl_obj_out,
    output logic           hs_out,
    output logic           vs_out,
    output logic           fetch_miss
);

    vid_pkg::row_t   disp;
    vid_pkg::pixel_t pix_sel;

    // next row goes in on the last pixel of the tile
    assign load = cen && (&h[2:0]);

    // pixel j sits at bits 2j+1:2j
    assign pix_sel = disp[{h[2:0], 1'b0} +: 2];

    // display row is a blank tile when the fetch did not make it
    always_ff @(posedge clk) begin
        if (load) disp <= row_ok ? row : '0;
    end

    // one cen of delay keeps pixel and timing together
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pix          <= '0;
            h_out        <= 9'(`VID_H_RESET);
            v_out        <= 9'(`VID_V_RESET);
            lhbl_out     <= 1'b0;
            lvbl_out     <= 1'b0;
            lhbl_obj_out <= 1'b0;
            lvbl_obj_out <= 1'b0;
            hs_out       <= 1'b0;
            vs_out       <= 1'b0;
            fetch_miss   <= 1'b0;
        end else begin
            // single cycle flag
            fetch_miss <= load && !row_ok;
            if (cen) begin
                pix          <= (lhbl && lvbl) ? pix_sel : '0;
                h_out        <= h;
                v_out        <= v;
                lhbl_out     <= lhbl;
                lvbl_out     <= lvbl;
                lhbl_obj_out <= lhbl_obj;
                lvbl_obj_out <= lvbl_obj;
                hs_out       <= hs;
                vs_out       <= vs;
            end
        end
    end

    // a miss marks one tile and never lasts into the next cycle
    assert property (@(posedge clk) disable iff (rst)
        fetch_miss |=> !fetch_miss);

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* tb.f */
+incdir+.
vid_pkg.sv
vid_timer.sv
char_fetch.sv
char_shifter.sv
vid_top.sv
tb_checker.sv
tb_top.sv

/* tb_checker.sv */
`include "vid_config.svh"

module tb_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  vid_pkg::pixel_t        pix,
    input  logic [8:0]             h_out,
    input  logic [8:0]             v_out,
    input  logic                   lhbl_out,
    input  logic                   lvbl_out,
    input  logic                   lhbl_obj_out,
    input  logic                   lvbl_obj_out,
    input  logic                   hs_out,
    input  logic                   vs_out,
    input  logic                   fetch_miss,
    input  logic                   rom_req,
    input  logic [`VID_ROM_AW-1:0] rom_addr,
    input  logic                   rom_ack,
    output logic [7:0]             ack_delay,
    output logic                   done,
    output int                     errors
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 250000;

    logic [15:0]            trace [0:191];
    logic                   abort;
    int                     test_errs;
    int                     tests_run;
    int                     tests_failed;
    int                     hs_count;
    int                     hs_viol;
    logic                   prev_req;
    logic                   prev_ack;
    logic [`VID_ROM_AW-1:0] prev_addr;

    // four-phase rules on the ROM port, every cycle
    always @(negedge clk) begin
        if (rst) begin
            prev_req <= 1'b0;
            prev_ack <= 1'b0;
            hs_count <= 0;
            hs_viol  <= 0;
        end else begin
            if (prev_req && !rom_req && !prev_ack) begin
                $display("handshake: rom_req fell before rom_ack rose");
                hs_viol <= hs_viol + 1;
            end
            if (!prev_req && rom_req && prev_ack) begin
                $display("handshake: rom_req rose while rom_ack was still high");
                hs_viol <= hs_viol + 1;
            end
            if ((prev_req || prev_ack) && rom_addr !== prev_addr) begin
                $display("ERR rom_addr: expected %h, got %h", prev_addr, rom_addr);
                hs_viol <= hs_viol + 1;
            end
            if (!prev_req && rom_req) hs_count <= hs_count + 1;
            prev_req  <= rom_req;
            prev_ack  <= rom_ack;
            prev_addr <= rom_addr;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            1: return "reset state";
            2: return "line and frame geometry";
            3: return "blanking windows";
            4: return "pixel data";
            5: return "slow ROM";
            default: return "handshake discipline";
        endcase
    endfunction

    // 0 hs, 1 vs, 2 miss flag, else reset
    function automatic logic sig(input int which);
        case (which)
            0: return hs_out;
            1: return vs_out;
            2: return fetch_miss;
            default: return rst;
        endcase
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        abort = 1'b1;
    endtask

    task automatic wait_level(input int which, input logic level, input string what);
        int n;
        n = 0;
        while (sig(which) !== level && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (sig(which) !== level) timed_out(what);
    endtask

    // negedge where the delayed counters show this position
    task automatic wait_point(input logic [8:0] v, input logic [8:0] h);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(h_out == h && v_out == v) && n < wait_limit);
        if (!(h_out == h && v_out == v)) timed_out("a sample position");
    endtask

    task automatic wait_step();
        logic [8:0] h0;
        int         n;
        h0 = h_out;
        n = 0;
        while (h_out == h0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (h_out == h0) timed_out("h_out to advance");
    endtask

    // cens while a signal keeps its level, stops on the negedge that shows the change
    task automatic count_cens(input int which, input logic level, output int n);
        int k;
        n = 0;
        k = 0;
        @(negedge clk);
        while (sig(which) == level && k < wait_limit) begin
            if (cen) n++;
            @(negedge clk);
            k++;
        end
        if (sig(which) == level) timed_out("a sync edge");
    endtask

    // hs rises while vs keeps its level
    task automatic count_lines(input logic level, output int n);
        int   k;
        logic hs_prev;
        n = 0;
        k = 0;
        hs_prev = hs_out;
        @(negedge clk);
        while (vs_out == level && k < wait_limit) begin
            if (hs_out && !hs_prev) n++;
            hs_prev = hs_out;
            @(negedge clk);
            k++;
        end
        if (vs_out == level) timed_out("a vertical sync edge");
    endtask

    task automatic report(input int t);
        tests_run++;
        if (errors != test_errs) tests_failed++;
        $display("test %0d %s: %s", t, test_name(t), (errors == test_errs) ? "ok" : "FAILED");
        test_errs = errors;
    endtask

    initial begin
        int         rec;
        int         cur;
        int         kind;
        int         n1;
        int         n2;
        logic [8:0] pv;
        logic [8:0] ph;
        logic [3:0] pexp;
        errors       = 0;
        done         = 1'b0;
        abort        = 1'b0;
        ack_delay    = 8'd2;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        $readmemh("vid_trace.txt", trace);
        rec = 0;
        cur = int'(trace[0]);
        wait_level(3, 1'b0, "reset release");
        while (!abort && rec < 32 && trace[rec * 6 + 1] != 16'hf) begin
            if (int'(trace[rec * 6]) != cur) begin
                report(cur);
                cur = int'(trace[rec * 6]);
            end
            kind      = int'(trace[rec * 6 + 1]);
            ack_delay = trace[rec * 6 + 2][7:0];
            pv        = trace[rec * 6 + 3][8:0];
            ph        = trace[rec * 6 + 4][8:0];
            pexp      = trace[rec * 6 + 5][3:0];
            case (kind)
                1: begin
                    check("h_out", 16'(h_out), 16'(`VID_H_RESET));
                    check("v_out", 16'(v_out), 16'(`VID_V_RESET));
                    check("rom_req", 16'(rom_req), 16'h0);
                    check("hs_out", 16'(hs_out), 16'h0);
                    check("vs_out", 16'(vs_out), 16'h0);
                    check("fetch_miss", 16'(fetch_miss), 16'h0);
                    check("pix", 16'(pix), 16'h0);
                    wait_step();
                    check("h_out", 16'(h_out), 16'(`VID_H_RESET + 1));
                    check("v_out", 16'(v_out), 16'(`VID_V_RESET));
                end
                2: begin
                    wait_level(0, 1'b0, "hs_out low");
                    wait_level(0, 1'b1, "hs_out high");
                    count_cens(0, 1'b1, n1);
                    count_cens(0, 1'b0, n2);
                    check("hs_out width", 16'(n1), 16'd28);
                    check("hs_out period", 16'(n1 + n2), 16'd384);
                    wait_level(1, 1'b0, "vs_out low");
                    wait_level(1, 1'b1, "vs_out high");
                    count_lines(1'b1, n1);
                    count_lines(1'b0, n2);
                    check("vs_out lines", 16'(n1), 16'd3);
                    check("vs_out frame lines", 16'(n1 + n2), 16'd262);
                end
                3: begin
                    wait_point(pv, ph);
                    check("lhbl,lvbl,lhbl_obj,lvbl_obj",
                          16'({lhbl_out, lvbl_out, lhbl_obj_out, lvbl_obj_out}), 16'(pexp));
                end
                4: begin
                    wait_point(pv, ph);
                    check("pix", 16'(pix), 16'(pexp));
                end
                5: begin
                    // the tile after a miss is blank for all eight pixels
                    wait_level(2, 1'b1, "fetch_miss");
                    repeat (8) begin
                        wait_step();
                        check("pix", 16'(pix), 16'h0);
                    end
                end
                7: begin
                    // two lines for a slow handshake to drain
                    repeat (2) begin
                        wait_level(0, 1'b0, "hs_out low");
                        wait_level(0, 1'b1, "hs_out high");
                    end
                end
                default: begin
                    errors += hs_viol;
                    if (hs_count == 0) begin
                        $display("no ROM handshake was seen");
                        errors++;
                    end
                end
            endcase
            rec++;
        end
        report(cur);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        done = 1'b1;
    end

endmodule

/* tb_top.sv */
`include "vid_config.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int seed_init  = 32'h1615;
    localparam int done_limit = 5000000;

    logic                   clk;
    logic                   rst;
    logic                   cen;
    logic                   rom_req;
    logic [`VID_ROM_AW-1:0] rom_addr;
    logic                   rom_ack;
    vid_pkg::row_t          rom_data;
    vid_pkg::pixel_t        pix;
    logic [8:0]             h_out;
    logic [8:0]             v_out;
    logic                   lhbl_out;
    logic                   lvbl_out;
    logic                   lhbl_obj_out;
    logic                   lvbl_obj_out;
    logic                   hs_out;
    logic                   vs_out;
    logic                   fetch_miss;

    // set by the checker from the trace
    logic [7:0]             ack_delay;
    logic                   done;
    int                     errors;

    integer                 seed;
    int                     phase;
    int                     wait_cnt;
    int                     target;
    int                     n;

    // ROM contents, each word is the address mixed with a shifted copy of itself
    function automatic vid_pkg::row_t rom_word(input logic [`VID_ROM_AW-1:0] a);
        vid_pkg::row_t w;
        w = vid_pkg::row_t'(a);
        return w ^ (w << 5);
    endfunction

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // pixel enable on every second clock
    always @(posedge clk) begin
        cen <= ~cen;
    end

    // ROM slave, answers each req after the trace delay plus a little jitter
    always @(posedge clk) begin
        if (rst) begin
            rom_ack <= 1'b0;
            phase   <= 0;
        end else begin
            case (phase)
                0: begin
                    if (rom_req) begin
                        target   <= int'(ack_delay) + int'($unsigned($random(seed)) % 3);
                        wait_cnt <= 0;
                        phase    <= 1;
                    end
                end
                1: begin
                    if (wait_cnt >= target) begin
                        rom_ack  <= 1'b1;
                        rom_data <= rom_word(rom_addr);
                        phase    <= 2;
                    end else begin
                        wait_cnt <= wait_cnt + 1;
                    end
                end
                2: begin
                    // ack stays up until the master lets go of req
                    if (!rom_req) begin
                        rom_ack <= 1'b0;
                        phase   <= 0;
                    end
                end
                default: phase <= 0;
            endcase
        end
    end

    vid_top vid_top_i (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .rom_req      (rom_req),
        .rom_addr     (rom_addr),
        .rom_ack      (rom_ack),
        .rom_data     (rom_data),
        .pix          (pix),
        .h_out        (h_out),
        .v_out        (v_out),
        .lhbl_out     (lhbl_out),
        .lvbl_out     (lvbl_out),
        .lhbl_obj_out (lhbl_obj_out),
        .lvbl_obj_out (lvbl_obj_out),
        .hs_out       (hs_out),
        .vs_out       (vs_out),
        .fetch_miss   (fetch_miss)
    );

    tb_checker checker_i (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .pix          (pix),
        .h_out        (h_out),
        .v_out        (v_out),
        .lhbl_out     (lhbl_out),
        .lvbl_out     (lvbl_out),
        .lhbl_obj_out (lhbl_obj_out),
        .lvbl_obj_out (lvbl_obj_out),
        .hs_out       (hs_out),
        .vs_out       (vs_out),
        .fetch_miss   (fetch_miss),
        .rom_req      (rom_req),
        .rom_addr     (rom_addr),
        .rom_ack      (rom_ack),
        .ack_delay    (ack_delay),
        .done         (done),
        .errors       (errors)
    );

    initial begin
        rst      = 1'b1;
        cen      = 1'b0;
        rom_ack  = 1'b0;
        rom_data = '0;
        seed     = seed_init;
        // reset for two clocks
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        n = 0;
        while (!done && n < done_limit) begin
            @(posedge clk);
            n++;
        end
        if (!done) $display("timeout: the checker did not finish its trace");
        if (done && errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vid_config.svh */
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// horizontal count range, 384 pixel slots per line
`define VID_H_START 128
`define VID_H_END 511
// vertical count range, 262 lines per frame
`define VID_V_START 250
`define VID_V_END 511
// counter values right after reset
`define VID_H_RESET 135
`define VID_V_RESET 496
// horizontal sync window in h counts
`define VID_HS_ON 178
`define VID_HS_OFF 206
// vertical sync window in lines
`define VID_VS_ON 507
`define VID_VS_OFF 510
// vertical blank starts at VB_ON, ends at VB_OFF
`define VID_VB_ON 496
`define VID_VB_OFF 272
// object line blanking is moved this many counts earlier
`define VID_OBJ_OFFSET 3
// graphics ROM, one 16-bit row holds 8 pixels of 2 bits
`define VID_ROM_AW 14
`define VID_ROM_DW 16

`endif

/* vid_pkg.sv */
`include "vid_config.svh"

package vid_pkg;

    // four-phase master state of the character fetch
    // idle: waiting for a tile start with ack low
    // req: request raised, waiting for ack
    // release: request dropped, waiting for ack to fall
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_req,
        fetch_release
    } fetch_state_t;

    // palette index of one character pixel
    typedef logic [1:0] pixel_t;

    // one graphics row as read from the ROM
    typedef logic [`VID_ROM_DW-1:0] row_t;

endpackage

/* vid_timer.sv */
`include "vid_config.svh"

module vid_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic       lhbl,
    output logic       lvbl,
    output logic       lhbl_obj,
    output logic       lvbl_obj,
    output logic       hs,
    output logic       vs
);

    localparam logic [8:0] h_start = 9'(`VID_H_START);
    localparam logic [8:0] h_end   = 9'(`VID_H_END);
    localparam logic [8:0] v_start = 9'(`VID_V_START);
    localparam logic [8:0] v_end   = 9'(`VID_V_END);
    // lhbl follows h[8], so it falls at 135 and rises at 263
    // the object version is shifted earlier by the offset
    localparam logic [8:0] obj_hb_on  = 9'(`VID_H_START + 7 - `VID_OBJ_OFFSET);
    localparam logic [8:0] obj_hb_off = 9'(256 + 7 - `VID_OBJ_OFFSET);
    // object buffer works two lines ahead of the display
    localparam logic [8:0] obj_vb_on  = 9'(`VID_VB_ON - 2);
    localparam logic [8:0] obj_vb_off = 9'(`VID_VB_OFF - 2);

    logic line_end;

    assign line_end = (h == h_end);

    // pixel counter wraps unconditionally at the line end
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            h <= 9'(`VID_H_RESET);
        end else if (cen) begin
            h <= line_end ? h_start : h + 9'd1;
        end
    end

    // line counter steps once per line
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            v <= 9'(`VID_V_RESET);
        end else if (cen && line_end) begin
            v <= (v == v_end) ? v_start : v + 9'd1;
        end
    end

    // blanking and sync are decoded one cen after the count
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lhbl     <= 1'b0;
            lvbl     <= 1'b0;
            lhbl_obj <= 1'b0;
            lvbl_obj <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
        end else if (cen) begin
            if (h == obj_hb_off) lhbl_obj <= 1'b1;
            if (h == obj_hb_on) lhbl_obj <= 1'b0;
            // line flags only move on the last pixel of a tile
            if (&h[2:0]) begin
                lhbl <= h[8];
                case (v)
                    9'(`VID_VB_ON):  lvbl <= 1'b0;
                    9'(`VID_VB_OFF): lvbl <= 1'b1;
                    obj_vb_on:       lvbl_obj <= 1'b0;
                    obj_vb_off:      lvbl_obj <= 1'b1;
                    9'(`VID_VS_ON):  vs <= 1'b1;
                    9'(`VID_VS_OFF): vs <= 1'b0;
                    default: ;
                endcase
            end
            if (h == 9'(`VID_HS_ON)) hs <= 1'b1;
            if (h == 9'(`VID_HS_OFF)) hs <= 1'b0;
        end
    end

    // h never drops below the first pixel slot of a line
    assert property (@(posedge clk) disable iff (rst)
        h >= h_start);

    // v never drops below the first line of a frame
    assert property (@(posedge clk) disable iff (rst)
        v >= v_start);

endmodule

/* vid_top.sv */
`include "vid_config.svh"

module vid_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    output logic                    rom_req,
    output logic [`VID_ROM_AW-1:0]  rom_addr,
    input  logic                    rom_ack,
    input  vid_pkg::row_t           rom_data,
    output vid_pkg::pixel_t         pix,
    output logic [8:0]              h_out,
    output logic [8:0]              v_out,
    output logic                    lhbl_out,
    output logic                    lvbl_out,
    output logic                    lhbl_obj_out,
    output logic                    lvbl_obj_out,
    output logic                    hs_out,
    output logic                    vs_out,
    output logic                    fetch_miss
);

    // raw timing from the counters
    logic [8:0] h;
    logic [8:0] v;
    logic       lhbl;
    logic       lvbl;
    logic       lhbl_obj;
    logic       lvbl_obj;
    logic       hs;
    logic       vs;

    // fetch to shifter
    vid_pkg::row_t row;
    logic          row_ok;
    logic          load;

    vid_timer timer_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .h        (h),
        .v        (v),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .lhbl_obj (lhbl_obj),
        .lvbl_obj (lvbl_obj),
        .hs       (hs),
        .vs       (vs)
    );

    char_fetch fetch_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .h        (h),
        .v        (v),
        .rom_req  (rom_req),
        .rom_addr (rom_addr),
        .rom_ack  (rom_ack),
        .rom_data (rom_data),
        .row      (row),
        .row_ok   (row_ok),
        .load     (load)
    );

    char_shifter shifter_i (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .h            (h),
        .v            (v),
        .lhbl         (lhbl),
        .lvbl         (lvbl),
        .lhbl_obj     (lhbl_obj),
        .lvbl_obj     (lvbl_obj),
        .hs           (hs),
        .vs           (vs),
        .row          (row),
        .row_ok       (row_ok),
        .load         (load),
        .pix          (pix),
        .h_out        (h_out),
        .v_out        (v_out),
        .lhbl_out     (lhbl_out),
        .lvbl_out     (lvbl_out),
        .lhbl_obj_out (lhbl_obj_out),
        .lvbl_obj_out (lvbl_obj_out),
        .hs_out       (hs_out),
        .vs_out       (vs_out),
        .fetch_miss   (fetch_miss)
    );

endmodule

/* vid_trace.txt */
// columns (hex): test kind ack_delay v h expected
// kind 1 reset, 2 sync geometry, 3 flags {lhbl,lvbl,lhbl_obj,lvbl_obj}, 4 pix at v,h
// kind 5 wait for a miss, 7 settle two lines, 6 handshake tally, f end
// ROM word = {2'b0,addr} ^ ({2'b0,addr} << 5) in 16 bits, addr = {v[7:0], h[8:3]}
1 1 02 000 000 0
2 2 02 000 000 0
3 3 02 10f 12c b
3 3 02 110 12c f
3 3 02 12c 084 f
3 3 02 12c 085 d
3 3 02 12c 087 d
3 3 02 12c 088 5
3 3 02 12c 104 5
3 3 02 12c 105 7
3 3 02 12c 107 7
3 3 02 12c 108 f
3 3 02 1ef 12c e
3 3 02 1f1 12c a
4 4 02 104 12c 0
4 4 02 119 10d 2
4 4 02 12c 0c8 0
4 4 02 12c 12c 3
4 4 02 15e 190 2
4 4 02 190 1c1 2
5 5 14 000 000 0
5 7 02 000 000 0
5 4 02 15e 190 2
5 4 02 190 1c1 2
6 6 02 000 000 0
f f 00 000 000 0
